//--- rv_decode.f
+incdir+design
+incdir+bench
design/rv_decode_pkg.sv
design/inst_fields_if.sv
design/inst_decoder.sv
design/register_file.sv
design/hazard_unit.sv
design/branch_unit.sv
design/id_ex_reg.sv
design/rv_decode.sv
bench/rv_decode_tb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= rv_decode.f
TB_TOP    ?= rv_decode_tb
RTL_TOP   ?= rv_decode
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wall
SIM_ARGS  ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(FILELIST) $(wildcard design/*.sv design/*.svh bench/*.sv bench/*.svh)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

sim: $(OBJ_DIR)/V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/rv_decode_tests.svh
`ifndef RV_DECODE_TESTS_SVH
`define RV_DECODE_TESTS_SVH

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, OP_REG};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
	input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

function automatic logic branch_expect(input logic [2:0] f3, input logic [31:0] a,
	input logic [31:0] b);
	case (f3)
		3'b000: return a == b;
		3'b001: return a != b;
		3'b100: return $signed(a) < $signed(b);
		3'b101: return $signed(a) >= $signed(b);
		3'b110: return a < b;
		default: return a >= b;
	endcase
endfunction

task automatic wb_write(input logic [4:0] rd, input logic [31:0] data);
	@(posedge i_clk);
	i_wb_en <= 1'b1;
	i_wb_rd_num <= rd;
	i_wb_data <= data;
	@(posedge i_clk);
	i_wb_en <= 1'b0;
	if (rd != 0) ref_regs[rd] = data;
endtask

// drives one instruction, optionally with a writeback in the same cycle.
task automatic send_inst_wb(input logic [31:0] inst, input logic [31:0] pc, input logic wb_en,
	input logic [4:0] wb_rd, input logic [31:0] wb_data);
	@(posedge i_clk);
	i_if_valid <= 1'b1;
	i_if_inst <= inst;
	i_if_pc <= pc;
	i_wb_en <= wb_en;
	i_wb_rd_num <= wb_rd;
	i_wb_data <= wb_data;
	wait_cycles = 0;
	@(negedge i_clk);
	while (!o_if_ready) begin
		wait_cycles++;
		@(negedge i_clk);
	end
	seen_taken = o_br_taken;
	seen_br_pc = o_br_pc;
	@(posedge i_clk);
	i_if_valid <= 1'b0;
	i_wb_en <= 1'b0;
	if (wb_en && wb_rd != 0) ref_regs[wb_rd] = wb_data;
	@(negedge i_clk);
	check_true(o_id_valid, "no bundle one cycle after acceptance");
	check_eq("o_id_pc", o_id_pc, pc);
endtask

task automatic send_inst(input logic [31:0] inst, input logic [31:0] pc);
	send_inst_wb(inst, pc, 1'b0, 5'd0, 32'd0);
endtask

task automatic check_fields(input logic [31:0] exp_imm, input logic [4:0] exp_rd,
	input logic [6:0] exp_op, input logic [2:0] exp_f3, input logic [6:0] exp_f7);
	check_eq("o_id_imm", o_id_imm, exp_imm);
	check_eq("o_id_rd_num", 32'(o_id_rd_num), 32'(exp_rd));
	check_eq("o_id_opcode", 32'(o_id_opcode), 32'(exp_op));
	check_eq("o_id_func3", 32'(o_id_func3), 32'(exp_f3));
	check_eq("o_id_func7", 32'(o_id_func7), 32'(exp_f7));
endtask

task automatic test_reset();
	@(negedge i_clk);
	check_true(!o_id_valid, "o_id_valid high after reset");
	check_true(!o_br_taken, "o_br_taken high after reset");
	send_inst(enc_r(7'd0, 5'd0, 5'd1, 3'd0, 5'd3), 32'h0000_0010);
	check_eq("o_id_rs1_val", o_id_rs1_val, 32'd0);
	check_eq("o_id_rs2_val", o_id_rs2_val, 32'd0);
endtask

task automatic test_writeback();
	logic [31:0] fresh;
	for (int r = 1; r < 32; r++) begin
		wb_write(5'(r), random_word());
	end
	for (int r = 1; r < 32; r++) begin
		send_inst(enc_r(7'd0, 5'(32 - r), 5'(r), 3'd0, 5'd1), 32'(r * 4));
		check_eq("o_id_rs1_val", o_id_rs1_val, ref_regs[r]);
		check_eq("o_id_rs2_val", o_id_rs2_val, ref_regs[32 - r]);
	end
	wb_write(5'd0, random_word());
	send_inst(enc_r(7'd0, 5'd0, 5'd0, 3'd0, 5'd2), 32'h0000_0100);
	check_eq("o_id_rs1_val", o_id_rs1_val, 32'd0);
	check_eq("o_id_rs2_val", o_id_rs2_val, 32'd0);
	// bypass of a write in the reading cycle.
	fresh = random_word();
	send_inst_wb(enc_r(7'd0, 5'd9, 5'd5, 3'd0, 5'd2), 32'h0000_0104, 1'b1, 5'd5, fresh);
	check_eq("o_id_rs1_val", o_id_rs1_val, fresh);
	check_eq("o_id_rs2_val", o_id_rs2_val, ref_regs[9]);
endtask

task automatic test_immediates();
	logic [31:0] inst;
	inst = enc_i(12'hFFB, 5'd2, 3'd0, 5'd7, OP_IMM);
	send_inst(inst, 32'h0000_0200);
	check_fields(32'hFFFF_FFFB, 5'd7, OP_IMM, 3'd0, 7'h7F);
	inst = enc_s(12'hFEC, 5'd3, 5'd4, 3'b010);
	send_inst(inst, 32'h0000_0204);
	check_fields(32'hFFFF_FFEC, 5'd12, OP_STORE, 3'd2, 7'h7F);
	inst = enc_b(13'h11A4, 5'd6, 5'd6, 3'b001);
	send_inst(inst, 32'h0000_0208);
	check_fields(32'hFFFF_F1A4, 5'd4, OP_BRANCH, 3'd1, 7'h4D);
	inst = {20'hABCDE, 5'd11, OP_LUI};
	send_inst(inst, 32'h0000_020C);
	check_fields(32'hABCD_E000, 5'd11, OP_LUI, 3'd6, 7'h55);
	inst = enc_j(21'h0F_1234, 5'd1);
	send_inst(inst, 32'h0000_0210);
	check_fields(32'h000F_1234, 5'd1, OP_JAL, 3'd1, 7'h11);
endtask

task automatic test_branches();
	logic [2:0] f3s [6];
	logic [4:0] lhs [3];
	logic [4:0] rhs [3];
	logic       exp;
	f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
	// equal, signed greater and unsigned less, then swapped.
	lhs = '{5'd1, 5'd1, 5'd2};
	rhs = '{5'd3, 5'd2, 5'd1};
	wb_write(5'd1, 32'd5);
	wb_write(5'd2, 32'hFFFF_FFFD);
	wb_write(5'd3, 32'd5);
	for (int f = 0; f < 6; f++) begin
		for (int p = 0; p < 3; p++) begin
			send_inst(enc_b(13'd16, rhs[p], lhs[p], f3s[f]), 32'h0000_0100);
			exp = branch_expect(f3s[f], ref_regs[lhs[p]], ref_regs[rhs[p]]);
			check_eq("o_br_taken", 32'(seen_taken), 32'(exp));
			if (exp) check_eq("o_br_pc", seen_br_pc, 32'h0000_0110);
		end
	end
	send_inst(enc_j(21'h40, 5'd1), 32'h0000_0200);
	check_eq("o_br_taken", 32'(seen_taken), 32'd1);
	check_eq("o_br_pc", seen_br_pc, 32'h0000_0240);
	send_inst(enc_i(12'h010, 5'd2, 3'd0, 5'd1, OP_JALR), 32'h0000_0300);
	check_eq("o_br_taken", 32'(seen_taken), 32'd1);
	check_eq("o_br_pc", seen_br_pc, (ref_regs[2] + 32'h10) & 32'hFFFF_FFFE);
endtask

task automatic hold_on_hazard(input logic [31:0] inst, input logic [4:0] ex_rd,
	input logic [4:0] mem_rd);
	@(posedge i_clk);
	i_id_ex_rd_num <= ex_rd;
	i_ex_mem_rd_num <= mem_rd;
	i_if_valid <= 1'b1;
	i_if_inst <= inst;
	i_if_pc <= 32'h0000_0400;
	repeat (3) begin
		@(negedge i_clk);
		check_true(!o_if_ready, "instruction accepted while a source is pending");
		check_true(!o_id_valid, "bundle issued during a stall");
	end
	@(posedge i_clk);
	i_id_ex_rd_num <= '0;
	i_ex_mem_rd_num <= '0;
	@(negedge i_clk);
	check_true(o_if_ready, "stall not released after clearing the destination");
	@(posedge i_clk);
	i_if_valid <= 1'b0;
	@(negedge i_clk);
	check_true(o_id_valid, "released instruction produced no bundle");
	check_eq("o_id_pc", o_id_pc, 32'h0000_0400);
endtask

task automatic test_hazards();
	hold_on_hazard(enc_r(7'd0, 5'd1, 5'd4, 3'd0, 5'd8), 5'd4, 5'd0);
	hold_on_hazard(enc_r(7'd0, 5'd7, 5'd1, 3'd0, 5'd8), 5'd0, 5'd7);
	@(posedge i_clk);
	i_id_ex_rd_num <= 5'd5;
	i_ex_mem_rd_num <= 5'd6;
	// rs2 field of an immediate op is not a source.
	send_inst(enc_i(12'h005, 5'd1, 3'd0, 5'd8, OP_IMM), 32'h0000_0500);
	check_eq("stall cycles", 32'(wait_cycles), 32'd0);
	send_inst({20'h00030, 5'd9, OP_LUI}, 32'h0000_0504);
	check_eq("stall cycles", 32'(wait_cycles), 32'd0);
	@(posedge i_clk);
	i_id_ex_rd_num <= '0;
	// zero sources against an empty execute slot.
	send_inst(enc_r(7'd0, 5'd0, 5'd0, 3'd0, 5'd9), 32'h0000_0508);
	check_eq("stall cycles", 32'(wait_cycles), 32'd0);
	@(posedge i_clk);
	i_id_ex_rd_num <= '0;
	i_ex_mem_rd_num <= '0;
endtask

task automatic test_backpressure();
	@(negedge i_clk);
	delivered.delete();
	@(posedge i_clk);
	i_ex_ready <= 1'b0;
	send_inst(enc_r(7'd0, 5'd2, 5'd1, 3'd0, 5'd3), 32'h0000_0600);
	@(posedge i_clk);
	i_if_valid <= 1'b1;
	i_if_inst <= enc_r(7'd0, 5'd4, 5'd3, 3'd0, 5'd5);
	i_if_pc <= 32'h0000_0604;
	repeat (3) begin
		@(negedge i_clk);
		check_true(!o_if_ready, "o_if_ready high under back-pressure");
		check_true(o_id_valid, "held bundle dropped under back-pressure");
		check_eq("o_id_pc", o_id_pc, 32'h0000_0600);
	end
	@(posedge i_clk);
	i_ex_ready <= 1'b1;
	@(negedge i_clk);
	check_true(o_if_ready, "o_if_ready low after back-pressure released");
	@(posedge i_clk);
	i_if_valid <= 1'b0;
	@(negedge i_clk);
	check_eq("o_id_pc", o_id_pc, 32'h0000_0604);
	@(posedge i_clk);
	@(negedge i_clk);
	check_eq("delivered count", 32'(delivered.size()), 32'd2);
	check_eq("first delivered pc", delivered[0], 32'h0000_0600);
	check_eq("second delivered pc", delivered[1], 32'h0000_0604);
endtask

`endif

//--- bench/rv_decode_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rv_decode_tb;

	localparam int NUM_TESTS = 6;
	localparam int CYCLES_PER_TEST = 200;

	// opcodes as given by the rv32i encoding tables.
	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_JAL = 7'b1101111;
	localparam logic [6:0] OP_JALR = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_REG = 7'b0110011;

	logic        i_clk;
	logic        i_arst_n;
	logic        i_if_valid;
	logic        o_if_ready;
	logic [31:0] i_if_inst;
	logic [31:0] i_if_pc;
	logic        i_wb_en;
	logic [4:0]  i_wb_rd_num;
	logic [31:0] i_wb_data;
	logic [4:0]  i_id_ex_rd_num;
	logic [4:0]  i_ex_mem_rd_num;
	logic        o_br_taken;
	logic [31:0] o_br_pc;
	logic        o_id_valid;
	logic        i_ex_ready;
	logic [31:0] o_id_pc;
	logic [31:0] o_id_rs1_val;
	logic [31:0] o_id_rs2_val;
	logic [31:0] o_id_imm;
	logic [4:0]  o_id_rd_num;
	logic [6:0]  o_id_opcode;
	logic [2:0]  o_id_func3;
	logic [6:0]  o_id_func7;

	// shadow of every register write.
	logic [31:0] ref_regs [0:31];
	logic [31:0] lfsr;
	logic        seen_taken;
	logic [31:0] seen_br_pc;
	int          wait_cycles;
	logic [31:0] delivered [$];

	rv_decode dut0(.*);

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	// log of every bundle that execute takes.
	always @(posedge i_clk) begin
		if (o_id_valid && i_ex_ready) begin
			delivered.push_back(o_id_pc);
		end
	end

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else fail_run($sformatf("mismatch %s: got %h, expected %h",
			name, got, exp));
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond === 1'b1) else fail_run(what);
	endtask

	// fibonacci lfsr, taps 32 22 2 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] random_word();
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr = lfsr_step(lfsr);
			w = {w[30:0], lfsr[0]};
		end
		return w;
	endfunction

	`include "rv_decode_tests.svh"

	initial begin
		repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge i_clk);
		fail_run("watchdog timeout, the DUT stopped responding");
	end

	initial begin
		lfsr = 32'd17;
		i_arst_n = 1'b0;
		i_if_valid = 1'b0;
		i_if_inst = '0;
		i_if_pc = '0;
		i_wb_en = 1'b0;
		i_wb_rd_num = '0;
		i_wb_data = '0;
		i_id_ex_rd_num = '0;
		i_ex_mem_rd_num = '0;
		i_ex_ready = 1'b1;
		for (int i = 0; i < 32; i++) begin
			ref_regs[i] = '0;
		end
		repeat (2) @(posedge i_clk);
		i_arst_n <= 1'b1;
		test_reset();
		test_writeback();
		test_immediates();
		test_branches();
		test_hazards();
		test_backpressure();
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- design/rv_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_decode_config.svh"

module rv_decode import rv_decode_pkg::*; (
	input  logic                      i_clk,
	input  logic                      i_arst_n,
	input  logic                      i_if_valid,
	output logic                      o_if_ready,
	input  logic [`RV_XLEN-1:0]       i_if_inst,
	input  logic [`RV_XLEN-1:0]       i_if_pc,
	input  logic                      i_wb_en,
	input  logic [`RV_REG_ADDR_W-1:0] i_wb_rd_num,
	input  logic [`RV_XLEN-1:0]       i_wb_data,
	input  logic [`RV_REG_ADDR_W-1:0] i_id_ex_rd_num,
	input  logic [`RV_REG_ADDR_W-1:0] i_ex_mem_rd_num,
	output logic                      o_br_taken,
	output logic [`RV_XLEN-1:0]       o_br_pc,
	output logic                      o_id_valid,
	input  logic                      i_ex_ready,
	output logic [`RV_XLEN-1:0]       o_id_pc,
	output logic [`RV_XLEN-1:0]       o_id_rs1_val,
	output logic [`RV_XLEN-1:0]       o_id_rs2_val,
	output logic [`RV_XLEN-1:0]       o_id_imm,
	output logic [`RV_REG_ADDR_W-1:0] o_id_rd_num,
	output logic [6:0]                o_id_opcode,
	output logic [2:0]                o_id_func3,
	output logic [6:0]                o_id_func7
);

	logic [`RV_XLEN-1:0] rs1_val;
	logic [`RV_XLEN-1:0] rs2_val;
	logic                stall;
	logic                fire;
	id_ex_t              dec_bundle;
	id_ex_t              out_bundle;

	inst_fields_if fields_if_0();

	inst_decoder inst_decoder_0(.i_inst(i_if_inst), .fields(fields_if_0.src));

	register_file register_file_0(.i_clk(i_clk), .i_arst_n(i_arst_n),
		.fields(fields_if_0.regs), .i_wb_en(i_wb_en), .i_wb_rd_num(i_wb_rd_num),
		.i_wb_data(i_wb_data), .o_rs1_val(rs1_val), .o_rs2_val(rs2_val));

	hazard_unit hazard_unit_0(.fields(fields_if_0.haz), .i_id_ex_rd_num(i_id_ex_rd_num),
		.i_ex_mem_rd_num(i_ex_mem_rd_num), .o_stall(stall));

	branch_unit branch_unit_0(.fields(fields_if_0.br), .i_pc(i_if_pc), .i_rs1_val(rs1_val),
		.i_rs2_val(rs2_val), .i_fire(fire), .o_br_taken(o_br_taken), .o_br_pc(o_br_pc));

	// decoded bundle toward execute.
	assign dec_bundle = '{pc: i_if_pc, rs1_val: rs1_val, rs2_val: rs2_val,
		imm: fields_if_0.imm, rd_num: fields_if_0.rd_num, opcode: fields_if_0.opcode,
		func3: fields_if_0.func3, func7: fields_if_0.func7};

	id_ex_reg id_ex_reg_0(.i_clk(i_clk), .i_arst_n(i_arst_n), .i_valid(i_if_valid),
		.o_ready(o_if_ready), .i_stall(stall), .i_bundle(dec_bundle), .o_fire(fire),
		.o_valid(o_id_valid), .i_ready(i_ex_ready), .o_bundle(out_bundle));

	assign o_id_pc = out_bundle.pc;
	assign o_id_rs1_val = out_bundle.rs1_val;
	assign o_id_rs2_val = out_bundle.rs2_val;
	assign o_id_imm = out_bundle.imm;
	assign o_id_rd_num = out_bundle.rd_num;
	assign o_id_opcode = out_bundle.opcode;
	assign o_id_func3 = out_bundle.func3;
	assign o_id_func7 = out_bundle.func7;

endmodule

`default_nettype wire

//--- design/id_ex_reg.sv
`timescale 1ns/100ps
`default_nettype none

module id_ex_reg import rv_decode_pkg::*; (
	input  logic   i_clk,
	input  logic   i_arst_n,
	input  logic   i_valid,
	output logic   o_ready,
	input  logic   i_stall,
	input  id_ex_t i_bundle,
	output logic   o_fire,
	output logic   o_valid,
	input  logic   i_ready,
	output id_ex_t o_bundle
);

	logic   valid_q;
	id_ex_t bundle_q;
	logic   slot_free;

	// slot is empty or drains this cycle.
	assign slot_free = !valid_q || i_ready;
	assign o_ready = !i_stall && slot_free;
	assign o_fire = i_valid && o_ready;

	// a stalled instruction leaves a bubble behind.
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			valid_q <= 1'b0;
		end else if (slot_free) begin
			valid_q <= o_fire;
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_fire) begin
			bundle_q <= i_bundle;
		end
	end

	assign o_valid = valid_q;
	assign o_bundle = bundle_q;

	a_hold_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(o_valid && !i_ready) |=> (o_valid && $stable(o_bundle)));

endmodule

`default_nettype wire

//--- design/branch_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_decode_config.svh"

module branch_unit import rv_decode_pkg::*; (
	inst_fields_if.br           fields,
	input  logic [`RV_XLEN-1:0] i_pc,
	input  logic [`RV_XLEN-1:0] i_rs1_val,
	input  logic [`RV_XLEN-1:0] i_rs2_val,
	input  logic                i_fire,
	output logic                o_br_taken,
	output logic [`RV_XLEN-1:0] o_br_pc
);

	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	logic                eq;
	logic                lt;
	logic                ltu;
	logic                taken;
	logic [`RV_XLEN-1:0] jalr_sum;

	assign eq = (i_rs1_val == i_rs2_val);
	assign lt = ($signed(i_rs1_val) < $signed(i_rs2_val));
	assign ltu = (i_rs1_val < i_rs2_val);

	always_comb begin
		taken = 1'b0;
		case (fields.opcode)
			OPC_BRANCH: begin
				case (fields.func3)
					F3_BEQ: taken = eq;
					F3_BNE: taken = !eq;
					F3_BLT: taken = lt;
					F3_BGE: taken = !lt;
					F3_BLTU: taken = ltu;
					F3_BGEU: taken = !ltu;
					default: taken = 1'b0;
				endcase
			end
			OPC_JAL, OPC_JALR: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	// jalr target has bit 0 cleared.
	assign jalr_sum = i_rs1_val + fields.imm;
	assign o_br_pc = (fields.opcode == OPC_JALR) ? {jalr_sum[`RV_XLEN-1:1], 1'b0} :
		(i_pc + fields.imm);

	// only redirect on the accepting cycle.
	assign o_br_taken = i_fire && taken;

endmodule

`default_nettype wire

//--- design/hazard_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_decode_config.svh"

module hazard_unit (
	inst_fields_if.haz                fields,
	input  logic [`RV_REG_ADDR_W-1:0] i_id_ex_rd_num,
	input  logic [`RV_REG_ADDR_W-1:0] i_ex_mem_rd_num,
	output logic                      o_stall
);

	logic rs1_hit;
	logic rs2_hit;

	// no forwarding, so any pending write to a source blocks.
	always_comb begin
		rs1_hit = fields.uses_rs1 && (fields.rs1_num != '0) &&
			((fields.rs1_num == i_id_ex_rd_num) || (fields.rs1_num == i_ex_mem_rd_num));
		rs2_hit = fields.uses_rs2 && (fields.rs2_num != '0) &&
			((fields.rs2_num == i_id_ex_rd_num) || (fields.rs2_num == i_ex_mem_rd_num));
		o_stall = rs1_hit || rs2_hit;

		// empty pipeline never stalls.
		a_idle_no_stall: assert (!((i_id_ex_rd_num == '0) && (i_ex_mem_rd_num == '0) &&
			o_stall));
	end

endmodule

`default_nettype wire

//--- design/register_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_decode_config.svh"

module register_file (
	input  logic                      i_clk,
	input  logic                      i_arst_n,
	inst_fields_if.regs               fields,
	input  logic                      i_wb_en,
	input  logic [`RV_REG_ADDR_W-1:0] i_wb_rd_num,
	input  logic [`RV_XLEN-1:0]       i_wb_data,
	output logic [`RV_XLEN-1:0]       o_rs1_val,
	output logic [`RV_XLEN-1:0]       o_rs2_val
);

	// register 0 is cleared at reset and never written.
	logic [`RV_XLEN-1:0] regs_q [0:`RV_REG_COUNT-1];
	logic                wb_live;

	assign wb_live = i_wb_en && (i_wb_rd_num != '0);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < `RV_REG_COUNT; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wb_live) begin
			regs_q[i_wb_rd_num] <= i_wb_data;
		end
	end

	// same-cycle writeback wins over the array.
	always_comb begin
		if (wb_live && (i_wb_rd_num == fields.rs1_num)) o_rs1_val = i_wb_data;
		else o_rs1_val = regs_q[fields.rs1_num];
	end

	always_comb begin
		if (wb_live && (i_wb_rd_num == fields.rs2_num)) o_rs2_val = i_wb_data;
		else o_rs2_val = regs_q[fields.rs2_num];
	end

	a_zero_reg: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		((fields.rs1_num == '0) -> (o_rs1_val == '0)) &&
		((fields.rs2_num == '0) -> (o_rs2_val == '0)));

endmodule

`default_nettype wire

//--- design/inst_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_decode_config.svh"

module inst_decoder import rv_decode_pkg::*; (
	input  logic [`RV_XLEN-1:0] i_inst,
	inst_fields_if.src          fields
);

	imm_fmt_e imm_fmt;
	logic     known;

	// format and source use by opcode.
	always_comb begin
		imm_fmt = IMM_NONE;
		known = 1'b1;
		fields.uses_rs1 = 1'b0;
		fields.uses_rs2 = 1'b0;
		case (opcode_e'(i_inst[6:0]))
			OPC_LUI, OPC_AUIPC: imm_fmt = IMM_U;
			OPC_JAL: imm_fmt = IMM_J;
			OPC_JALR, OPC_LOAD, OPC_OP_IMM: begin
				imm_fmt = IMM_I;
				fields.uses_rs1 = 1'b1;
			end
			OPC_BRANCH: begin
				imm_fmt = IMM_B;
				fields.uses_rs1 = 1'b1;
				fields.uses_rs2 = 1'b1;
			end
			OPC_STORE: begin
				imm_fmt = IMM_S;
				fields.uses_rs1 = 1'b1;
				fields.uses_rs2 = 1'b1;
			end
			OPC_OP: begin
				fields.uses_rs1 = 1'b1;
				fields.uses_rs2 = 1'b1;
			end
			default: known = 1'b0;
		endcase
	end

	// sign-extended immediate.
	always_comb begin
		case (imm_fmt)
			IMM_I: fields.imm = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:20]};
			IMM_S: fields.imm = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
			IMM_B: fields.imm = {{(`RV_XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7],
				i_inst[30:25], i_inst[11:8], 1'b0};
			IMM_U: fields.imm = {i_inst[31:12], 12'b0};
			IMM_J: fields.imm = {{(`RV_XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12],
				i_inst[20], i_inst[30:21], 1'b0};
			default: fields.imm = '0;
		endcase
	end

	assign fields.opcode = opcode_e'(i_inst[6:0]);
	assign fields.func3 = i_inst[14:12];
	assign fields.func7 = i_inst[31:25];
	assign fields.rs1_num = i_inst[19:15];
	assign fields.rs2_num = i_inst[24:20];
	// unknown opcodes write nothing.
	assign fields.rd_num = known ? i_inst[11:7] : '0;

endmodule

`default_nettype wire

//--- design/inst_fields_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_decode_config.svh"

interface inst_fields_if import rv_decode_pkg::*; ();
	opcode_e                   opcode;
	logic [2:0]                func3;
	logic [6:0]                func7;
	logic [`RV_REG_ADDR_W-1:0] rs1_num;
	logic [`RV_REG_ADDR_W-1:0] rs2_num;
	logic [`RV_REG_ADDR_W-1:0] rd_num;
	logic [`RV_XLEN-1:0]       imm;
	logic                      uses_rs1;
	logic                      uses_rs2;

	modport src(output opcode, func3, func7, rs1_num, rs2_num, rd_num, imm, uses_rs1, uses_rs2);
	modport regs(input rs1_num, rs2_num);
	modport haz(input rs1_num, rs2_num, uses_rs1, uses_rs2);
	modport br(input opcode, func3, imm);
endinterface

`default_nettype wire

//--- design/rv_decode_pkg.sv
`default_nettype none

`include "rv_decode_config.svh"

package rv_decode_pkg;

	// rv32i major opcodes.
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_e;

	// immediate layout selected by the opcode.
	typedef enum logic [2:0] {
		IMM_I,
		IMM_S,
		IMM_B,
		IMM_U,
		IMM_J,
		IMM_NONE
	} imm_fmt_e;

	// bundle handed to execute.
	typedef struct packed {
		logic [`RV_XLEN-1:0]       pc;
		logic [`RV_XLEN-1:0]       rs1_val;
		logic [`RV_XLEN-1:0]       rs2_val;
		logic [`RV_XLEN-1:0]       imm;
		logic [`RV_REG_ADDR_W-1:0] rd_num;
		opcode_e                   opcode;
		logic [2:0]                func3;
		logic [6:0]                func7;
	} id_ex_t;

endpackage

`default_nettype wire

//--- design/rv_decode_config.svh
`ifndef RV_DECODE_CONFIG_SVH
`define RV_DECODE_CONFIG_SVH

// data and address width.
`define RV_XLEN 32

// architectural register count.
`define RV_REG_COUNT 32

// width of a register number.
`define RV_REG_ADDR_W 5

`endif
